//--- common/autotest_pkg.sv
// shared record layout and SD host request/response types, imported by every autotest block
`default_nettype none

package autotest_pkg;

  // one test record per SD block
  localparam int BLOCK_BYTES = 512;

  // signature sits at the start of the record, most significant byte first
  localparam int SIG_BYTES = 4;
  localparam logic [31:0] RECORD_SIGNATURE = 32'hAABBCCDD;

  // execution cycle count in a failure record, lsb first
  localparam int EXEC_TIME_BYTES = 8;

  // byte position inside a block
  typedef logic [9:0] byte_cnt_t;

  // toward the SD host
  // init, rd_byte and wr_byte are strobes held until busy rises
  typedef struct packed {
    logic       init;
    logic       rd_block;
    logic       rd_byte;
    logic       wr_block;
    logic       wr_byte;
    logic [7:0] wdata;
  } sd_req_t;

  // from the SD host, rdata valid from the fall of busy
  typedef struct packed {
    logic       busy;
    logic [7:0] rdata;
  } sd_rsp_t;

endpackage

`default_nettype wire

//--- hw/exec_timer.sv
// UUT execution cycle counter, counts while the UUT runs and flags a timeout
`timescale 1ns/1ps
`default_nettype none

module exec_timer #(
  parameter logic [63:0] TIMEOUT_CYCLES = 64'd268435456
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        clear_i,
  input  logic        run_i,
  output logic [63:0] count_o,
  output logic        timeout_o
);

  logic [63:0] count_q;

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      count_q <= '0;
    end else if (run_i) begin
      count_q <= count_q + 64'd1;
    end
  end

  // value holds after the run for the failure record
  assign count_o   = count_q;
  assign timeout_o = (count_q > TIMEOUT_CYCLES);

endmodule

`default_nettype wire

//--- hw/test_stats.sv
// run statistics, block address, error count, uptime and the debug output select
`timescale 1ns/1ps
`default_nettype none

module test_stats #(
  parameter logic [31:0] START_BLOCK = 32'h00100000
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        next_block_i,
  input  logic        error_i,
  input  logic        halted_i,
  input  logic [1:0]  debug_sel_i,
  output logic [31:0] block_addr_o,
  output logic [31:0] debug_o
);

  logic [31:0] block_q;
  logic [31:0] err_q;
  logic [63:0] uptime_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      block_q  <= START_BLOCK;
      err_q    <= '0;
      uptime_q <= '0;
    end else begin
      if (next_block_i) block_q <= block_q + 32'd1;
      if (error_i) err_q <= err_q + 32'd1;
      // uptime freezes once the run has halted
      if (!halted_i) uptime_q <= uptime_q + 64'd1;
    end
  end

  assign block_addr_o = block_q;

  always_comb begin
    case (debug_sel_i)
      2'd0:    debug_o = block_q - START_BLOCK;
      2'd1:    debug_o = err_q;
      2'd2:    debug_o = uptime_q[31:0];
      default: debug_o = {31'd0, halted_i};
    endcase
  end

endmodule

`default_nettype wire

//--- hw/sequencer/record_store.sv
// test record registers, loaded byte by byte from the SD block and read back for write-back
`timescale 1ns/1ps
`default_nettype none

module record_store
  import autotest_pkg::*;
#(
  parameter int OP_A_WIDTH   = 32,
  parameter int OP_B_WIDTH   = 32,
  parameter int RESULT_WIDTH = 32
) (
  input  logic                    clk,
  input  logic                    rst,
  input  byte_cnt_t               byte_pos_i,
  input  logic                    load_i,
  input  logic [7:0]              rdata_i,
  input  logic                    clear_i,
  input  logic                    capture_i,
  input  logic [RESULT_WIDTH-1:0] uut_result_i,
  input  logic [63:0]             exec_count_i,
  output logic [7:0]              wb_byte_o,
  output logic [OP_A_WIDTH-1:0]   op_a_o,
  output logic [OP_B_WIDTH-1:0]   op_b_o,
  output logic                    sig_ok_o,
  output logic                    match_o
);

  // field start offsets inside the block
  localparam int A_OFF   = SIG_BYTES;
  localparam int B_OFF   = A_OFF + OP_A_WIDTH / 8;
  localparam int E_OFF   = B_OFF + OP_B_WIDTH / 8;
  localparam int R_OFF   = E_OFF + RESULT_WIDTH / 8;
  localparam int T_OFF   = R_OFF + RESULT_WIDTH / 8;
  localparam int PAD_OFF = T_OFF + EXEC_TIME_BYTES;

  logic [31:0]             sig_q;
  logic [OP_A_WIDTH-1:0]   op_a_q;
  logic [OP_B_WIDTH-1:0]   op_b_q;
  logic [RESULT_WIDTH-1:0] exp_q;
  logic [RESULT_WIDTH-1:0] res_q;
  int                      pos;

  assign pos = int'(byte_pos_i);

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      sig_q  <= '0;
      op_a_q <= '0;
      op_b_q <= '0;
      exp_q  <= '0;
      res_q  <= '0;
    end else begin
      if (load_i) begin
        // signature msb first, the rest lsb first
        if (pos < A_OFF) sig_q[8*(A_OFF-1-pos) +: 8] <= rdata_i;
        else if (pos < B_OFF) op_a_q[8*(pos-A_OFF) +: 8] <= rdata_i;
        else if (pos < E_OFF) op_b_q[8*(pos-B_OFF) +: 8] <= rdata_i;
        else if (pos < R_OFF) exp_q[8*(pos-E_OFF) +: 8] <= rdata_i;
      end
      if (capture_i) res_q <= uut_result_i;
    end
  end

  always_comb begin
    wb_byte_o = 8'hFF;
    if (pos < A_OFF) wb_byte_o = sig_q[8*(A_OFF-1-pos) +: 8];
    else if (pos < B_OFF) wb_byte_o = op_a_q[8*(pos-A_OFF) +: 8];
    else if (pos < E_OFF) wb_byte_o = op_b_q[8*(pos-B_OFF) +: 8];
    else if (pos < R_OFF) wb_byte_o = exp_q[8*(pos-E_OFF) +: 8];
    else if (pos < T_OFF) wb_byte_o = res_q[8*(pos-R_OFF) +: 8];
    else if (pos < PAD_OFF) wb_byte_o = exec_count_i[8*(pos-T_OFF) +: 8];
  end

  assign op_a_o   = op_a_q;
  assign op_b_o   = op_b_q;
  assign sig_ok_o = (sig_q == RECORD_SIGNATURE);
  assign match_o  = (exp_q == res_q);

endmodule

`default_nettype wire

//--- hw/sequencer/autotest_sequencer.sv
// autotest FSM, reads a record per SD block, releases the UUT and writes back failed records
`timescale 1ns/1ps
`default_nettype none

module autotest_sequencer
  import autotest_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  sd_rsp_t    sd_rsp_i,
  output sd_req_t    sd_req_o,
  input  logic       uut_done_i,
  output logic       uut_rst_o,
  output byte_cnt_t  byte_pos_o,
  output logic       load_o,
  output logic       clear_o,
  output logic       capture_o,
  input  logic       sig_ok_i,
  input  logic       match_i,
  input  logic [7:0] wb_byte_i,
  output logic       tmr_clear_o,
  output logic       tmr_run_o,
  input  logic       timeout_i,
  output logic       next_block_o,
  output logic       error_o,
  output logic       halted_o
);

  typedef enum logic [3:0] {
    S_INIT_REQ, S_INIT_WAIT, S_IDLE, S_RD_BYTE, S_RD_WAIT, S_CHECK, S_START,
    S_RUN, S_CAPTURE, S_COMPARE, S_WR_BYTE, S_WR_WAIT, S_NEXT, S_HALT
  } state_t;

  state_t    state;
  state_t    state_nxt;
  byte_cnt_t byte_cnt;
  logic      cnt_clr;
  logic      cnt_inc;
  logic      last_byte;

  assign last_byte  = (byte_cnt == byte_cnt_t'(BLOCK_BYTES - 1));
  assign byte_pos_o = byte_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= S_INIT_REQ;
      byte_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (cnt_clr) begin
        byte_cnt <= '0;
      end else if (cnt_inc) begin
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    state_nxt      = state;
    sd_req_o       = '0;
    // position only moves between bytes, so wdata holds while wr_byte is up
    sd_req_o.wdata = wb_byte_i;
    uut_rst_o      = 1'b1;
    load_o         = 1'b0;
    clear_o        = 1'b0;
    capture_o      = 1'b0;
    tmr_clear_o    = 1'b0;
    tmr_run_o      = 1'b0;
    next_block_o   = 1'b0;
    error_o        = 1'b0;
    halted_o       = 1'b0;
    cnt_clr        = 1'b0;
    cnt_inc        = 1'b0;

    case (state)
      S_INIT_REQ: begin
        sd_req_o.init = 1'b1;
        if (sd_rsp_i.busy) state_nxt = S_INIT_WAIT;
      end
      S_INIT_WAIT: begin
        if (!sd_rsp_i.busy) state_nxt = S_IDLE;
      end
      S_IDLE: begin
        clear_o     = 1'b1;
        tmr_clear_o = 1'b1;
        cnt_clr     = 1'b1;
        if (!sd_rsp_i.busy) state_nxt = S_RD_BYTE;
      end
      S_RD_BYTE: begin
        sd_req_o.rd_block = 1'b1;
        sd_req_o.rd_byte  = 1'b1;
        if (sd_rsp_i.busy) state_nxt = S_RD_WAIT;
      end
      S_RD_WAIT: begin
        sd_req_o.rd_block = 1'b1;
        if (!sd_rsp_i.busy) begin
          load_o = 1'b1;
          // whole block is read even past the record fields
          if (last_byte) begin
            state_nxt = S_CHECK;
          end else begin
            cnt_inc   = 1'b1;
            state_nxt = S_RD_BYTE;
          end
        end
      end
      S_CHECK: begin
        state_nxt = sig_ok_i ? S_START : S_HALT;
      end
      S_START: begin
        uut_rst_o = 1'b0;
        tmr_run_o = 1'b1;
        state_nxt = S_RUN;
      end
      S_RUN: begin
        uut_rst_o = 1'b0;
        if (uut_done_i || timeout_i) begin
          state_nxt = S_CAPTURE;
        end else begin
          tmr_run_o = 1'b1;
        end
      end
      S_CAPTURE: begin
        // UUT still released so its result is stable at the capture edge
        uut_rst_o = 1'b0;
        capture_o = 1'b1;
        state_nxt = S_COMPARE;
      end
      S_COMPARE: begin
        cnt_clr = 1'b1;
        if (match_i) begin
          state_nxt = S_NEXT;
        end else begin
          error_o   = 1'b1;
          state_nxt = S_WR_BYTE;
        end
      end
      S_WR_BYTE: begin
        sd_req_o.wr_block = 1'b1;
        sd_req_o.wr_byte  = 1'b1;
        if (sd_rsp_i.busy) state_nxt = S_WR_WAIT;
      end
      S_WR_WAIT: begin
        sd_req_o.wr_block = 1'b1;
        if (!sd_rsp_i.busy) begin
          if (last_byte) begin
            state_nxt = S_NEXT;
          end else begin
            cnt_inc   = 1'b1;
            state_nxt = S_WR_BYTE;
          end
        end
      end
      S_NEXT: begin
        next_block_o = 1'b1;
        state_nxt    = S_IDLE;
      end
      S_HALT: begin
        // bad signature ends the run until reset
        halted_o = 1'b1;
      end
      default: begin
        state_nxt = S_INIT_REQ;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/autotest_top.sv
// autotest top level, connects the sequencer, record store, execution timer and statistics
`timescale 1ns/1ps
`default_nettype none

module autotest_top
  import autotest_pkg::*;
#(
  parameter int          OP_A_WIDTH     = 32,
  parameter int          OP_B_WIDTH     = 32,
  parameter int          RESULT_WIDTH   = 32,
  parameter logic [63:0] TIMEOUT_CYCLES = 64'd268435456,
  parameter logic [31:0] START_BLOCK    = 32'h00100000
) (
  input  logic                    clk,
  input  logic                    rst,
  output sd_req_t                 sd_req_o,
  output logic [31:0]             sd_block_addr_o,
  input  sd_rsp_t                 sd_rsp_i,
  output logic                    uut_rst_o,
  input  logic                    uut_done_i,
  output logic [OP_A_WIDTH-1:0]   uut_op_a_o,
  output logic [OP_B_WIDTH-1:0]   uut_op_b_o,
  input  logic [RESULT_WIDTH-1:0] uut_result_i,
  input  logic [1:0]              debug_sel_i,
  output logic [31:0]             debug_o
);

  byte_cnt_t   byte_pos;
  logic        load;
  logic        clear;
  logic        capture;
  logic        sig_ok;
  logic        match;
  logic [7:0]  wb_byte;
  logic        tmr_clear;
  logic        tmr_run;
  logic        timeout;
  logic [63:0] exec_count;
  logic        next_block;
  logic        error;
  logic        halted;

  autotest_sequencer i_sequencer (
    .clk          (clk),
    .rst          (rst),
    .sd_rsp_i     (sd_rsp_i),
    .sd_req_o     (sd_req_o),
    .uut_done_i   (uut_done_i),
    .uut_rst_o    (uut_rst_o),
    .byte_pos_o   (byte_pos),
    .load_o       (load),
    .clear_o      (clear),
    .capture_o    (capture),
    .sig_ok_i     (sig_ok),
    .match_i      (match),
    .wb_byte_i    (wb_byte),
    .tmr_clear_o  (tmr_clear),
    .tmr_run_o    (tmr_run),
    .timeout_i    (timeout),
    .next_block_o (next_block),
    .error_o      (error),
    .halted_o     (halted)
  );

  record_store #(
    .OP_A_WIDTH   (OP_A_WIDTH),
    .OP_B_WIDTH   (OP_B_WIDTH),
    .RESULT_WIDTH (RESULT_WIDTH)
  ) i_record_store (
    .clk          (clk),
    .rst          (rst),
    .byte_pos_i   (byte_pos),
    .load_i       (load),
    .rdata_i      (sd_rsp_i.rdata),
    .clear_i      (clear),
    .capture_i    (capture),
    .uut_result_i (uut_result_i),
    .exec_count_i (exec_count),
    .wb_byte_o    (wb_byte),
    .op_a_o       (uut_op_a_o),
    .op_b_o       (uut_op_b_o),
    .sig_ok_o     (sig_ok),
    .match_o      (match)
  );

  exec_timer #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) i_exec_timer (
    .clk       (clk),
    .rst       (rst),
    .clear_i   (tmr_clear),
    .run_i     (tmr_run),
    .count_o   (exec_count),
    .timeout_o (timeout)
  );

  test_stats #(
    .START_BLOCK (START_BLOCK)
  ) i_test_stats (
    .clk          (clk),
    .rst          (rst),
    .next_block_i (next_block),
    .error_i      (error),
    .halted_i     (halted),
    .debug_sel_i  (debug_sel_i),
    .block_addr_o (sd_block_addr_o),
    .debug_o      (debug_o)
  );

endmodule

`default_nettype wire

//--- tests/sd_card_model.sv
// behavioral SD host with a block image that answers the busy handshake with random latency
`timescale 1ns/1ps
`default_nettype none

module sd_card_model
  import autotest_pkg::*;
#(
  parameter logic [31:0] BASE_BLOCK = 32'h00100000,
  parameter int          NUM_BLOCKS = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  sd_req_t     sd_req_i,
  input  logic [31:0] block_addr_i,
  output sd_rsp_t     sd_rsp_o
);

  // card image is filled by the testbench before reset is released
  logic [7:0] image [NUM_BLOCKS][BLOCK_BYTES];
  logic       written [NUM_BLOCKS];
  logic       range_error;

  logic       busy_q = 1'b0;
  logic [7:0] rdata_q = 8'h00;
  sd_req_t    req_q;
  int         phase;
  int         delay;
  int         hold;
  int         pos;
  int         blk;

  assign sd_rsp_o = '{busy: busy_q, rdata: rdata_q};

  // phase 0 is idle, 1 waits to go busy, 2 is busy
  always @(negedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      rdata_q <= 8'h00;
      phase = 0;
      pos = 0;
      range_error = 1'b0;
      for (int i = 0; i < NUM_BLOCKS; i++) written[i] = 1'b0;
    end else begin
      blk = int'(block_addr_i - BASE_BLOCK);
      if (!sd_req_i.rd_block && !sd_req_i.wr_block) pos = 0;
      if (phase == 0 && (sd_req_i.init || sd_req_i.rd_byte || sd_req_i.wr_byte)) begin
        // wdata is taken with the request
        req_q = sd_req_i;
        delay = $urandom_range(2, 0);
        phase = 1;
      end
      if (phase == 1) begin
        if (delay == 0) begin
          busy_q <= 1'b1;
          hold = $urandom_range(3, 1);
          phase = 2;
        end else begin
          delay = delay - 1;
        end
      end else if (phase == 2) begin
        hold = hold - 1;
        if (hold == 0) begin
          if (req_q.rd_byte || req_q.wr_byte) begin
            if (blk < 0 || blk >= NUM_BLOCKS || pos >= BLOCK_BYTES) begin
              range_error = 1'b1;
            end else if (req_q.rd_byte) begin
              rdata_q <= image[blk][pos];
            end else begin
              image[blk][pos] = req_q.wdata;
              written[blk] = 1'b1;
            end
            pos = pos + 1;
          end
          busy_q <= 1'b0;
          phase = 0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/autotest_asserts.sv
// concurrent checks on the sequencer's SD handshake, bound into every sequencer instance
`timescale 1ns/1ps
`default_nettype none

module autotest_asserts
  import autotest_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input sd_req_t sd_req_i,
  input sd_rsp_t sd_rsp_i,
  input logic    uut_rst_i
);

  // read and write blocks never overlap
  a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (rst)
    !(sd_req_i.rd_block && sd_req_i.wr_block))
    else $error("rd_block and wr_block both active");

  a_uut_held_in_reset: assert property (@(posedge clk) disable iff (rst)
    (sd_req_i.rd_block || sd_req_i.wr_block) |-> uut_rst_i)
    else $error("UUT released during an SD block operation");

  // write strobe stays up until the host goes busy
  a_wr_byte_held: assert property (@(posedge clk) disable iff (rst)
    (sd_req_i.wr_byte && !sd_rsp_i.busy) |=> sd_req_i.wr_byte)
    else $error("wr_byte dropped before busy rose");

endmodule

bind autotest_sequencer autotest_asserts i_asserts (
  .clk       (clk),
  .rst       (rst),
  .sd_req_i  (sd_req_o),
  .sd_rsp_i  (sd_rsp_i),
  .uut_rst_i (uut_rst_o)
);

`default_nettype wire

//--- tests/autotest_tb.sv
// autotest testbench that loads test records into the SD card model and checks the run results
`timescale 1ns/1ps
`default_nettype none

module autotest_tb
  import autotest_pkg::*;
();

  localparam int          CLK_PERIOD     = 100;
  localparam logic [63:0] TIMEOUT_CYCLES = 64'd200;
  localparam logic [31:0] START_BLOCK    = 32'h00100000;
  localparam int          NUM_ROWS       = 6;
  localparam int          HALT_TIMEOUT   = 200000;

  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] expected;
    logic [31:0] delay;
  } row_t;

  row_t        rows [NUM_ROWS];
  logic        clk;
  logic        rst;
  sd_req_t     sd_req;
  sd_rsp_t     sd_rsp;
  logic [31:0] sd_block_addr;
  logic        uut_rst;
  logic        uut_done = 1'b0;
  logic [31:0] uut_op_a;
  logic [31:0] uut_op_b;
  logic [31:0] uut_result = 32'd0;
  logic [1:0]  debug_sel;
  logic [31:0] debug;
  int          uut_cycles;

  autotest_top #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .START_BLOCK    (START_BLOCK)
  ) i_autotest_top (
    .clk             (clk),
    .rst             (rst),
    .sd_req_o        (sd_req),
    .sd_block_addr_o (sd_block_addr),
    .sd_rsp_i        (sd_rsp),
    .uut_rst_o       (uut_rst),
    .uut_done_i      (uut_done),
    .uut_op_a_o      (uut_op_a),
    .uut_op_b_o      (uut_op_b),
    .uut_result_i    (uut_result),
    .debug_sel_i     (debug_sel),
    .debug_o         (debug)
  );

  sd_card_model #(
    .BASE_BLOCK (START_BLOCK),
    .NUM_BLOCKS (NUM_ROWS + 1)
  ) i_card (
    .clk          (clk),
    .rst          (rst),
    .sd_req_i     (sd_req),
    .block_addr_i (sd_block_addr),
    .sd_rsp_o     (sd_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  // result the UUT leaves behind is zero when it runs past the timeout
  function automatic logic [31:0] captured_result(row_t row);
    if (row.delay > TIMEOUT_CYCLES) return 32'd0;
    return row.a + row.b;
  endfunction

  function automatic int expected_errors();
    int n;
    n = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].expected != captured_result(rows[r])) n++;
    end
    return n;
  endfunction

  // failure record holds sig, a, b, expected and result, then padding after the count
  function automatic logic [7:0] expected_wb_byte(row_t row, logic [31:0] captured, int pos);
    if (pos < 4) return RECORD_SIGNATURE[8*(3-pos) +: 8];
    if (pos < 8) return row.a[8*(pos-4) +: 8];
    if (pos < 12) return row.b[8*(pos-8) +: 8];
    if (pos < 16) return row.expected[8*(pos-12) +: 8];
    if (pos < 20) return captured[8*(pos-16) +: 8];
    return 8'hFF;
  endfunction

  task automatic load_table();
    rows[0] = '{a: 32'd1, b: 32'd2, expected: 32'd3, delay: 32'd5};
    rows[1] = '{a: 32'h12345678, b: 32'h11111111, expected: 32'h23456789, delay: 32'd12};
    // sum wraps to zero
    rows[2] = '{a: 32'hFFFFFFFF, b: 32'd1, expected: 32'd0, delay: 32'd3};
    // wrong expected value
    rows[3] = '{a: 32'd100, b: 32'd23, expected: 32'd124, delay: 32'd7};
    // UUT too slow and runs into the timeout
    rows[4] = '{a: 32'h0A0B0C0D, b: 32'h01010101, expected: 32'h0B0C0D0E, delay: 32'd300};
    rows[5] = '{a: 32'hDEAD0000, b: 32'h0000BEEF, expected: 32'hDEADBEEF, delay: 32'd1};
  endtask

  task automatic fill_card_image();
    logic [31:0] sig;
    for (int b = 0; b <= NUM_ROWS; b++) begin
      // block after the table carries a broken signature
      sig = (b < NUM_ROWS) ? RECORD_SIGNATURE : ~RECORD_SIGNATURE;
      for (int p = 0; p < BLOCK_BYTES; p++) i_card.image[b][p] = 8'($urandom);
      for (int k = 0; k < 4; k++) i_card.image[b][k] = sig[8*(3-k) +: 8];
      if (b < NUM_ROWS) begin
        for (int k = 0; k < 4; k++) begin
          i_card.image[b][4+k] = rows[b].a[8*k +: 8];
          i_card.image[b][8+k] = rows[b].b[8*k +: 8];
          i_card.image[b][12+k] = rows[b].expected[8*k +: 8];
        end
      end
    end
  endtask

  task automatic read_debug(input logic [1:0] sel, output logic [31:0] value);
    @(negedge clk);
    debug_sel = sel;
    #(CLK_PERIOD / 4);
    value = debug;
  endtask

  task automatic wait_for_halt();
    logic [31:0] value;
    int          cycles;
    cycles = 0;
    value = 32'd0;
    while (!value[0]) begin
      if (cycles >= HALT_TIMEOUT) begin
        $display("timeout: the sequencer did not halt within %0d cycles", HALT_TIMEOUT);
        stop_with_failure();
      end
      read_debug(2'd3, value);
      cycles++;
    end
  endtask

  task automatic check_written_blocks();
    logic [31:0] captured;
    logic [63:0] exec_count;
    string       tag;
    for (int r = 0; r < NUM_ROWS; r++) begin
      captured = captured_result(rows[r]);
      tag = $sformatf("row %0d", r);
      if (rows[r].expected == captured) begin
        check_value({tag, " block untouched"}, 64'd0, 64'(i_card.written[r]));
      end else begin
        check_value({tag, " block written"}, 64'd1, 64'(i_card.written[r]));
        exec_count = 64'd0;
        for (int p = 0; p < BLOCK_BYTES; p++) begin
          if (p >= 20 && p < 28) begin
            exec_count[8*(p-20) +: 8] = i_card.image[r][p];
          end else begin
            check_value($sformatf("%s byte %0d", tag, p),
                        64'(expected_wb_byte(rows[r], captured, p)),
                        64'(i_card.image[r][p]));
          end
        end
        check_value({tag, " exec count in range"}, 64'd1,
                    64'(exec_count != 64'd0 && exec_count <= TIMEOUT_CYCLES + 64'd1));
      end
    end
    check_value("halt block untouched", 64'd0, 64'(i_card.written[NUM_ROWS]));
  endtask

  // UUT model adds its operands after the row's delay
  always @(negedge clk) begin : uut_model
    int row;
    row = int'(sd_block_addr - START_BLOCK);
    if (rst || uut_rst) begin
      uut_cycles = 0;
      uut_done <= 1'b0;
      uut_result <= 32'd0;
    end else if (row >= 0 && row < NUM_ROWS) begin
      check_value($sformatf("row %0d op_a", row), 64'(rows[row].a), 64'(uut_op_a));
      check_value($sformatf("row %0d op_b", row), 64'(rows[row].b), 64'(uut_op_b));
      uut_cycles = uut_cycles + 1;
      if (uut_cycles >= int'(rows[row].delay)) begin
        uut_done <= 1'b1;
        uut_result <= uut_op_a + uut_op_b;
      end
    end
  end

  initial begin : main
    logic [31:0] value;
    logic [31:0] uptime_before;
    rst = 1'b1;
    debug_sel = 2'd0;
    void'($urandom(32'h32d4));
    load_table();
    fill_card_image();
    repeat (3) @(negedge clk);
    rst = 1'b0;
    wait_for_halt();
    read_debug(2'd3, value);
    check_value("halted flag", 64'd1, 64'(value));
    read_debug(2'd0, value);
    check_value("blocks processed", 64'(NUM_ROWS), 64'(value));
    read_debug(2'd1, value);
    check_value("error count", 64'(expected_errors()), 64'(value));
    check_written_blocks();
    check_value("card address range", 64'd0, 64'(i_card.range_error));
    // uptime stays frozen after the halt
    read_debug(2'd2, uptime_before);
    repeat (20) @(negedge clk);
    read_debug(2'd2, value);
    check_value("uptime frozen", 64'(uptime_before), 64'(value));
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
common/autotest_pkg.sv
hw/exec_timer.sv
hw/test_stats.sv
hw/sequencer/record_store.sv
hw/sequencer/autotest_sequencer.sv
hw/autotest_top.sv
tests/sd_card_model.sv
tests/autotest_asserts.sv
tests/autotest_tb.sv

//--- Makefile
# Verilator build for the autotest testbench
# override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= autotest_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the exit status of the simulation is the test result
run: compile
	$(SIM)

clean:
	rm -rf $(BUILD_DIR)
